/* Makefile */
# Verilator build and run for the multi-cycle scalar ALU testbench
# Any variable can be overridden, for example make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_multi_cycle_scalar_alu
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* fp_adder_align.sv */
/*
 * FP adder stage one. Unpacks both operands, puts the larger magnitude
 * first, works out the alignment shift and flags inf and NaN inputs
 */
`timescale 1ns/1ps
`include "fp_alu_config.svh"

module fp_adder_align import fp_alu_pkg::*; (
	input  logic clk,
	input  logic rst_i,
	input  alu_op_t op_i,
	input  fp_word_u operand1_i,
	input  fp_word_u operand2_i,
	output logic [`FP_SIG_W+2:0] sig_large_o,
	output logic [`FP_SIG_W+2:0] sig_small_o,
	output logic [`FP_EXP_W-1:0] exp_o,
	output logic [4:0] shift_o,
	output logic sign_o,
	output logic subtract_o,
	output logic inf_o,
	output logic nan_o
);
	logic sign2_eff;
	logic swap;
	logic zero1;
	logic zero2;
	logic inf1;
	logic inf2;
	logic nan1;
	logic nan2;
	logic subtract;
	logic [`FP_SIG_W+2:0] sig1;
	logic [`FP_SIG_W+2:0] sig2;
	logic [`FP_EXP_W-1:0] exp_large;
	logic [`FP_EXP_W-1:0] exp_diff;

	// Subtract and all compares negate operand two
	assign sign2_eff = operand2_i.f.sign ^ (op_i inside {OP_FSUB, OP_FGTR, OP_FLT, OP_FGTE, OP_FLTE});
	assign swap = operand2_i.raw[`FP_WORD_W-2:0] > operand1_i.raw[`FP_WORD_W-2:0];
	assign subtract = operand1_i.f.sign ^ sign2_eff;

	// Denormals read as zero
	assign zero1 = operand1_i.f.exponent == '0;
	assign zero2 = operand2_i.f.exponent == '0;
	assign inf1 = &operand1_i.f.exponent && operand1_i.f.significand == '0;
	assign inf2 = &operand2_i.f.exponent && operand2_i.f.significand == '0;
	assign nan1 = &operand1_i.f.exponent && operand1_i.f.significand != '0;
	assign nan2 = &operand2_i.f.exponent && operand2_i.f.significand != '0;

	// Hidden bit on top, two guard zeros below
	assign sig1 = zero1 ? '0 : {1'b1, operand1_i.f.significand, 2'b00};
	assign sig2 = zero2 ? '0 : {1'b1, operand2_i.f.significand, 2'b00};

	assign exp_large = swap ? operand2_i.f.exponent : operand1_i.f.exponent;
	assign exp_diff = swap ? operand2_i.f.exponent - operand1_i.f.exponent
		: operand1_i.f.exponent - operand2_i.f.exponent;

	always_ff @(posedge clk)
	begin
		sig_large_o <= swap ? sig2 : sig1;
		sig_small_o <= swap ? sig1 : sig2;
		exp_o <= exp_large;
		shift_o <= (|exp_diff[`FP_EXP_W-1:5]) ? 5'd31 : exp_diff[4:0];  // Saturate
		sign_o <= swap ? sign2_eff : operand1_i.f.sign;
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			subtract_o <= 1'b0;
			inf_o <= 1'b0;
			nan_o <= 1'b0;
		end
		else
		begin
			subtract_o <= subtract;
			inf_o <= inf1 || inf2;
			nan_o <= nan1 || nan2 || (inf1 && inf2 && subtract);  // inf - inf
		end
	end

endmodule

/* fp_adder_sum.sv */
/*
 * FP adder stages two and three. Shifts the smaller significand into
 * line, then adds or subtracts the pair
 */
`timescale 1ns/1ps
`include "fp_alu_config.svh"

module fp_adder_sum (
	input  logic clk,
	input  logic rst_i,
	input  logic [`FP_SIG_W+2:0] sig_large_i,
	input  logic [`FP_SIG_W+2:0] sig_small_i,
	input  logic [`FP_EXP_W-1:0] exp_i,
	input  logic [4:0] shift_i,
	input  logic sign_i,
	input  logic subtract_i,
	input  logic inf_i,
	input  logic nan_i,
	output logic [`FP_SIG_W+3:0] sum_o,
	output logic [`FP_EXP_W-1:0] exp_o,
	output logic sign_o,
	output logic inf_o,
	output logic nan_o
);
	logic [`FP_SIG_W+2:0] large_q;
	logic [`FP_SIG_W+2:0] small_q;
	logic [`FP_EXP_W-1:0] exp_q;
	logic sign_q;
	logic subtract_q;
	logic inf_q;
	logic nan_q;
	logic [`FP_SIG_W+3:0] sum;

	// Large magnitude first, so this never goes negative
	assign sum = subtract_q ? {1'b0, large_q} - {1'b0, small_q}
		: {1'b0, large_q} + {1'b0, small_q};

	always_ff @(posedge clk)
	begin
		large_q <= sig_large_i;
		small_q <= sig_small_i >> shift_i;  // Shifted-out bits are lost
		exp_q <= exp_i;
		sign_q <= sign_i;
		sum_o <= sum;
		exp_o <= exp_q;
		sign_o <= (sum == '0) ? 1'b0 : sign_q;  // Exact zero is positive
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			subtract_q <= 1'b0;
			inf_q <= 1'b0;
			nan_q <= 1'b0;
			inf_o <= 1'b0;
			nan_o <= 1'b0;
		end
		else
		begin
			subtract_q <= subtract_i;
			inf_q <= inf_i;
			nan_q <= nan_i;
			inf_o <= inf_q;
			nan_o <= nan_q;
		end
	end

endmodule

/* fp_alu_config.svh */
/*
 * Field widths and pipeline depth for the multi-cycle scalar ALU,
 * single-precision format with four stages
 */
`ifndef FP_ALU_CONFIG_SVH
`define FP_ALU_CONFIG_SVH

// Exponent field width
`define FP_EXP_W 8

// Stored significand width, hidden bit not counted
`define FP_SIG_W 23

// Full word width
`define FP_WORD_W 32

// Edges from accept to result
`define ALU_LATENCY 4

`endif

/* fp_alu_pkg.sv */
/*
 * Shared types for the multi-cycle scalar ALU: the operation encoding
 * and the operand word with its float and integer views
 */
`include "fp_alu_config.svh"

package fp_alu_pkg;

	typedef enum logic [2:0]
	{
		OP_FADD,
		OP_FSUB,
		OP_FMUL,
		OP_IMUL,
		OP_FGTR,
		OP_FLT,
		OP_FGTE,
		OP_FLTE
	} alu_op_t;

	typedef struct packed
	{
		logic sign;
		logic [`FP_EXP_W-1:0] exponent;
		logic [`FP_SIG_W-1:0] significand;
	} fp_fields_t;

	// Float view for FP ops, raw view for OP_IMUL
	typedef union packed
	{
		fp_fields_t f;
		logic [`FP_WORD_W-1:0] raw;
	} fp_word_u;

endpackage

/* fp_normalize.sv */
/*
 * Shared normalizer. Moves the leading one to the hidden position,
 * truncates, fixes the exponent and applies the special-case words
 */
`timescale 1ns/1ps
`include "fp_alu_config.svh"

module fp_normalize import fp_alu_pkg::*; (
	input  logic [2*`FP_SIG_W+1:0] significand_i,
	input  logic signed [`FP_EXP_W+1:0] exponent_i,
	input  logic sign_i,
	input  logic inf_i,
	input  logic nan_i,
	output fp_word_u word_o
);
	localparam int SIG_IN_W = 2*`FP_SIG_W + 2;
	localparam logic signed [`FP_EXP_W+1:0] HIDDEN_POS = 2*`FP_SIG_W;  // exponent_i refers here
	localparam logic signed [`FP_EXP_W+1:0] EXP_LIMIT = (1 << `FP_EXP_W) - 1;
	localparam logic [`FP_WORD_W-1:0] NAN_WORD = '1;
	localparam logic [`FP_WORD_W-1:0] INF_WORD = {1'b0, {`FP_EXP_W{1'b1}}, {`FP_SIG_W{1'b0}}};

	logic [5:0] lead;
	logic [SIG_IN_W-1:0] shifted;
	logic signed [`FP_EXP_W+1:0] exp_adj;
	logic sig_zero;
	logic overflow;
	logic underflow;

	// Highest set bit wins
	always_comb
	begin
		lead = '0;
		for (int i = 0; i < SIG_IN_W; i++)
			if (significand_i[i])
				lead = 6'(i);
	end

	assign shifted = significand_i << (6'(SIG_IN_W - 1) - lead);
	assign exp_adj = exponent_i + $signed({{(`FP_EXP_W-4){1'b0}}, lead}) - HIDDEN_POS;
	assign sig_zero = significand_i == '0;
	assign overflow = !sig_zero && exp_adj >= EXP_LIMIT;
	assign underflow = exp_adj <= 0;

	always_comb
	begin
		word_o.raw = '0;
		if (nan_i)
			word_o.raw = NAN_WORD;
		else if (inf_i || overflow)
			word_o.raw = INF_WORD;
		else if (!sig_zero && !underflow)
		begin
			word_o.f.sign = sign_i;
			word_o.f.exponent = exp_adj[`FP_EXP_W-1:0];
			word_o.f.significand = shifted[SIG_IN_W-2 -: `FP_SIG_W];  // Truncate
		end
	end

endmodule

/* integer_multiplier.sv */
/*
 * Three-stage unsigned 32 by 32 multiplier. Works on 16-bit halves so
 * each stage holds one narrow multiply or one add
 */
`timescale 1ns/1ps
`include "fp_alu_config.svh"

module integer_multiplier (
	input  logic clk,
	input  logic [`FP_WORD_W-1:0] multiplicand_i,
	input  logic [`FP_WORD_W-1:0] multiplier_i,
	output logic [2*`FP_WORD_W-1:0] product_o
);
	localparam int HALF_W = `FP_WORD_W / 2;

	logic [`FP_WORD_W-1:0] a_q;
	logic [`FP_WORD_W-1:0] b_q;
	logic [`FP_WORD_W-1:0] pp_ll;
	logic [`FP_WORD_W-1:0] pp_lh;
	logic [`FP_WORD_W-1:0] pp_hl;
	logic [`FP_WORD_W-1:0] pp_hh;
	logic [2*`FP_WORD_W-1:0] cross_sum;

	// Middle terms sit one half-word up
	assign cross_sum = ({{HALF_W{1'b0}}, pp_lh, {HALF_W{1'b0}}})
		+ ({{HALF_W{1'b0}}, pp_hl, {HALF_W{1'b0}}});

	always_ff @(posedge clk)
	begin
		a_q <= multiplicand_i;
		b_q <= multiplier_i;

		pp_ll <= a_q[HALF_W-1:0] * b_q[HALF_W-1:0];
		pp_lh <= a_q[HALF_W-1:0] * b_q[`FP_WORD_W-1:HALF_W];
		pp_hl <= a_q[`FP_WORD_W-1:HALF_W] * b_q[HALF_W-1:0];
		pp_hh <= a_q[`FP_WORD_W-1:HALF_W] * b_q[`FP_WORD_W-1:HALF_W];

		product_o <= {pp_hh, pp_ll} + cross_sum;
	end

endmodule

/* multi_cycle_scalar_alu.sv */
/*
 * Four-stage scalar ALU for FP add, subtract, multiply and compare plus
 * 32-bit integer multiply. One issue per cycle, no stalls
 */
`timescale 1ns/1ps
`include "fp_alu_config.svh"

module multi_cycle_scalar_alu import fp_alu_pkg::*; (
	input  logic clk,
	input  logic rst_i,
	input  logic valid_i,
	input  alu_op_t op_i,
	input  fp_word_u operand1_i,
	input  fp_word_u operand2_i,
	output logic valid_o,
	output logic [`FP_WORD_W-1:0] result_o
);
	localparam int STAGES = `ALU_LATENCY - 1;
	localparam int LAST = STAGES - 1;
	localparam logic signed [`FP_EXP_W+1:0] BIAS = (1 << (`FP_EXP_W - 1)) - 1;

	logic valid_q [STAGES];
	alu_op_t op_q [STAGES];
	logic signed [`FP_EXP_W+1:0] mul_exp_q [STAGES];
	logic mul_sign_q [STAGES];
	logic mul_inf_q [STAGES];
	logic mul_nan_q [STAGES];

	logic [`FP_SIG_W+2:0] align_sig_large;
	logic [`FP_SIG_W+2:0] align_sig_small;
	logic [`FP_EXP_W-1:0] align_exp;
	logic [4:0] align_shift;
	logic align_sign;
	logic align_subtract;
	logic align_inf;
	logic align_nan;
	logic [`FP_SIG_W+3:0] add_sum;
	logic [`FP_EXP_W-1:0] add_exp;
	logic add_sign;
	logic add_inf;
	logic add_nan;

	logic [`FP_SIG_W:0] hsig1;
	logic [`FP_SIG_W:0] hsig2;
	logic [`FP_WORD_W-1:0] mul_a;
	logic [`FP_WORD_W-1:0] mul_b;
	logic [2*`FP_WORD_W-1:0] product;
	logic zero1;
	logic zero2;
	logic inf1;
	logic inf2;
	logic nan1;
	logic nan2;

	logic [2*`FP_SIG_W+1:0] norm_sig;
	logic signed [`FP_EXP_W+1:0] norm_exp;
	logic norm_sign;
	logic norm_inf;
	logic norm_nan;
	fp_word_u norm_word;
	logic cmp_zero;
	logic cmp_neg;
	logic cmp_true;
	logic [`FP_WORD_W-1:0] result_next;

	fp_adder_align u_align (
		.clk(clk),
		.rst_i(rst_i),
		.op_i(op_i),
		.operand1_i(operand1_i),
		.operand2_i(operand2_i),
		.sig_large_o(align_sig_large),
		.sig_small_o(align_sig_small),
		.exp_o(align_exp),
		.shift_o(align_shift),
		.sign_o(align_sign),
		.subtract_o(align_subtract),
		.inf_o(align_inf),
		.nan_o(align_nan)
	);

	fp_adder_sum u_sum (
		.clk(clk),
		.rst_i(rst_i),
		.sig_large_i(align_sig_large),
		.sig_small_i(align_sig_small),
		.exp_i(align_exp),
		.shift_i(align_shift),
		.sign_i(align_sign),
		.subtract_i(align_subtract),
		.inf_i(align_inf),
		.nan_i(align_nan),
		.sum_o(add_sum),
		.exp_o(add_exp),
		.sign_o(add_sign),
		.inf_o(add_inf),
		.nan_o(add_nan)
	);

	// Operand classes for the float multiply
	assign zero1 = operand1_i.f.exponent == '0;
	assign zero2 = operand2_i.f.exponent == '0;
	assign inf1 = &operand1_i.f.exponent && operand1_i.f.significand == '0;
	assign inf2 = &operand2_i.f.exponent && operand2_i.f.significand == '0;
	assign nan1 = &operand1_i.f.exponent && operand1_i.f.significand != '0;
	assign nan2 = &operand2_i.f.exponent && operand2_i.f.significand != '0;
	assign hsig1 = zero1 ? '0 : {1'b1, operand1_i.f.significand};
	assign hsig2 = zero2 ? '0 : {1'b1, operand2_i.f.significand};

	// Raw words for integer multiply, significands otherwise
	assign mul_a = (op_i == OP_IMUL) ? operand1_i.raw
		: {{(`FP_WORD_W-`FP_SIG_W-1){1'b0}}, hsig1};
	assign mul_b = (op_i == OP_IMUL) ? operand2_i.raw
		: {{(`FP_WORD_W-`FP_SIG_W-1){1'b0}}, hsig2};

	integer_multiplier u_mult (
		.clk(clk),
		.multiplicand_i(mul_a),
		.multiplier_i(mul_b),
		.product_o(product)
	);

	always_ff @(posedge clk)
	begin
		mul_exp_q[0] <= $signed({2'b00, operand1_i.f.exponent})
			+ $signed({2'b00, operand2_i.f.exponent}) - BIAS;
		mul_sign_q[0] <= operand1_i.f.sign ^ operand2_i.f.sign;
		for (int s = 1; s < STAGES; s++)
		begin
			mul_exp_q[s] <= mul_exp_q[s-1];
			mul_sign_q[s] <= mul_sign_q[s-1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int s = 0; s < STAGES; s++)
			begin
				valid_q[s] <= 1'b0;
				op_q[s] <= OP_FADD;
				mul_inf_q[s] <= 1'b0;
				mul_nan_q[s] <= 1'b0;
			end
		end
		else
		begin
			valid_q[0] <= valid_i;
			op_q[0] <= op_i;
			mul_inf_q[0] <= inf1 || inf2;
			mul_nan_q[0] <= nan1 || nan2 || (inf1 && zero2) || (inf2 && zero1);  // inf * 0
			for (int s = 1; s < STAGES; s++)
			begin
				valid_q[s] <= valid_q[s-1];
				op_q[s] <= op_q[s-1];
				mul_inf_q[s] <= mul_inf_q[s-1];
				mul_nan_q[s] <= mul_nan_q[s-1];
			end
		end
	end

	// Product leading bit lands at 2^46 or 2^47, the adder sum is lined up to match
	always_comb
	begin
		if (op_q[LAST] == OP_FMUL)
		begin
			norm_sig = product[2*`FP_SIG_W+1:0];
			norm_exp = mul_exp_q[LAST];
			norm_sign = mul_sign_q[LAST];
			norm_inf = mul_inf_q[LAST];
			norm_nan = mul_nan_q[LAST];
		end
		else
		begin
			norm_sig = {add_sum, {(`FP_SIG_W-2){1'b0}}};
			norm_exp = {2'b00, add_exp};
			norm_sign = add_sign;
			norm_inf = add_inf;
			norm_nan = add_nan;
		end
	end

	fp_normalize u_norm (
		.significand_i(norm_sig),
		.exponent_i(norm_exp),
		.sign_i(norm_sign),
		.inf_i(norm_inf),
		.nan_i(norm_nan),
		.word_o(norm_word)
	);

	// Compare against the normalized difference op1 - op2
	assign cmp_zero = norm_word.raw[`FP_WORD_W-2:0] == '0;
	assign cmp_neg = norm_word.f.sign;

	always_comb
	begin
		case (op_q[LAST])
			OP_FGTR: cmp_true = !cmp_zero && !cmp_neg;
			OP_FLT: cmp_true = cmp_neg;
			OP_FGTE: cmp_true = !cmp_neg;
			OP_FLTE: cmp_true = cmp_zero || cmp_neg;
			default: cmp_true = 1'b0;
		endcase
	end

	always_comb
	begin
		if (op_q[LAST] == OP_IMUL)
			result_next = product[`FP_WORD_W-1:0];  // Low half only
		else if (op_q[LAST] inside {OP_FGTR, OP_FLT, OP_FGTE, OP_FLTE})
			result_next = {{(`FP_WORD_W-1){1'b0}}, cmp_true};
		else
			result_next = norm_word.raw;
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			valid_o <= 1'b0;
			result_o <= '0;
		end
		else
		begin
			valid_o <= valid_q[LAST];
			result_o <= result_next;
		end
	end

endmodule

/* tb_multi_cycle_scalar_alu.sv */
/*
 * Self-checking testbench for the multi-cycle scalar ALU. Issues directed
 * and random operations, predicts each word with a reference model and
 * checks value and latency of every result in issue order
 */
`timescale 1ns/1ps
`include "fp_alu_config.svh"

module tb_multi_cycle_scalar_alu import fp_alu_pkg::*; ();
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES = 8;
	localparam int N_DIRECTED = 26;
	localparam int N_IMUL = 20;
	localparam int N_PAIRS = 7;
	localparam int N_RANDOM = 300;
	// Random ops may each bring one bubble
	localparam int OP_SLOTS = N_DIRECTED + N_IMUL + 1 + 4*N_PAIRS + 2*N_RANDOM;
	localparam int TIMEOUT = RESET_CYCLES + IDLE_CYCLES + OP_SLOTS + `ALU_LATENCY + 50;

	logic clk;
	logic rst_i;
	logic valid_i;
	alu_op_t op_i;
	fp_word_u operand1_i;
	fp_word_u operand2_i;
	logic valid_o;
	logic [`FP_WORD_W-1:0] result_o;

	logic [31:0] expect_q [$];
	int due_q [$];
	alu_op_t op_hist [$];
	logic [31:0] a_hist [$];
	logic [31:0] b_hist [$];
	int cycle_count = 0;
	int checks = 0;
	int value_errors = 0;
	int timing_errors = 0;
	int other_errors = 0;
	integer seed;

	multi_cycle_scalar_alu dut (
		.clk(clk),
		.rst_i(rst_i),
		.valid_i(valid_i),
		.op_i(op_i),
		.operand1_i(operand1_i),
		.operand2_i(operand2_i),
		.valid_o(valid_o),
		.result_o(result_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic is_inf(input logic [31:0] w);
		return &w[30:23] && w[22:0] == 0;
	endfunction

	function automatic logic is_nan(input logic [31:0] w);
		return &w[30:23] && w[22:0] != 0;
	endfunction

	// Bit ref_pos of mag carries the biased exponent exp_ref
	function automatic logic [31:0] pack_float(input logic sign, input int exp_ref,
		input int ref_pos, input logic [63:0] mag, input logic inf, input logic nan);
		int lead;
		int e;
		logic [63:0] top;
		if (nan)
			return 32'hFFFF_FFFF;
		if (inf)
			return 32'h7F80_0000;  // Canonical infinity
		if (mag == 0)
			return 32'h0;
		lead = 0;
		for (int i = 0; i < 64; i++)
			if (mag[i])
				lead = i;
		e = exp_ref + lead - ref_pos;
		if (e >= 255)
			return 32'h7F80_0000;
		if (e <= 0)
			return 32'h0;
		top = mag << (63 - lead);
		return {sign, 8'(e), top[62:40]};  // Truncated fraction below the leading one
	endfunction

	function automatic logic [31:0] add_floats(input logic [31:0] a, input logic [31:0] b,
		input logic negate_b);
		logic sign_b;
		logic swap;
		logic sub;
		int exp_a;
		int exp_b;
		logic [63:0] sig_a;
		logic [63:0] sig_b;
		logic [63:0] big;
		logic [63:0] small_sig;
		logic [63:0] sum;
		sign_b = b[31] ^ negate_b;
		exp_a = a[30:23];
		exp_b = b[30:23];
		sig_a = (exp_a == 0) ? 64'd0 : {38'd0, 1'b1, a[22:0], 2'b00};
		sig_b = (exp_b == 0) ? 64'd0 : {38'd0, 1'b1, b[22:0], 2'b00};
		swap = b[30:0] > a[30:0];
		sub = a[31] ^ sign_b;
		big = swap ? sig_b : sig_a;
		small_sig = (swap ? sig_a : sig_b) >> (swap ? exp_b - exp_a : exp_a - exp_b);
		sum = sub ? big - small_sig : big + small_sig;
		return pack_float(swap ? sign_b : a[31], swap ? exp_b : exp_a, 25, sum,
			is_inf(a) || is_inf(b), is_nan(a) || is_nan(b) || (is_inf(a) && is_inf(b) && sub));
	endfunction

	function automatic logic [31:0] multiply_floats(input logic [31:0] a, input logic [31:0] b);
		int exp_a;
		int exp_b;
		logic [63:0] sig_a;
		logic [63:0] sig_b;
		exp_a = a[30:23];
		exp_b = b[30:23];
		sig_a = (exp_a == 0) ? 64'd0 : {40'd0, 1'b1, a[22:0]};
		sig_b = (exp_b == 0) ? 64'd0 : {40'd0, 1'b1, b[22:0]};
		return pack_float(a[31] ^ b[31], exp_a + exp_b - 127, 46, sig_a * sig_b,
			is_inf(a) || is_inf(b),
			is_nan(a) || is_nan(b) || (is_inf(a) && exp_b == 0) || (is_inf(b) && exp_a == 0));
	endfunction

	function automatic logic [31:0] model_alu(input alu_op_t op, input logic [31:0] a,
		input logic [31:0] b);
		logic [31:0] diff;
		logic zero;
		logic neg;
		diff = add_floats(a, b, 1'b1);
		zero = diff[30:0] == 0;
		neg = diff[31];
		case (op)
			OP_FADD: return add_floats(a, b, 1'b0);
			OP_FSUB: return diff;
			OP_FMUL: return multiply_floats(a, b);
			OP_IMUL: return a * b;  // Low word
			OP_FGTR: return {31'd0, !zero && !neg};
			OP_FLT: return {31'd0, neg};
			OP_FGTE: return {31'd0, !neg};
			default: return {31'd0, zero || neg};
		endcase
	endfunction

	task automatic issue_op(input alu_op_t op, input logic [31:0] a, input logic [31:0] b);
		@(posedge clk);
		#1;
		valid_i = 1'b1;
		op_i = op;
		operand1_i.raw = a;
		operand2_i.raw = b;
		expect_q.push_back(model_alu(op, a, b));
		due_q.push_back(cycle_count + `ALU_LATENCY);
		op_hist.push_back(op);
		a_hist.push_back(a);
		b_hist.push_back(b);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#1;
		valid_i = 1'b0;
	endtask

	task automatic compare_all(input logic [31:0] a, input logic [31:0] b);
		issue_op(OP_FGTR, a, b);
		issue_op(OP_FLT, a, b);
		issue_op(OP_FGTE, a, b);
		issue_op(OP_FLTE, a, b);
	endtask

	// Mostly moderate exponents with some zeros, specials, huge and tiny values
	task automatic random_float(output logic [31:0] w);
		logic [31:0] r;
		logic [7:0] e;
		r = $random(seed);
		case (r[3:0])
			4'd0: e = 8'd0;
			4'd1: e = 8'hFF;
			4'd2: e = 8'd230 + 8'(r[7:4]);
			4'd3: e = 8'd1 + 8'(r[7:4]);
			default: e = 8'd96 + 8'(r[9:4]);
		endcase
		w = {r[31], e, 23'($random(seed))};
	endtask

	task automatic drop_head();
		void'(expect_q.pop_front());
		void'(due_q.pop_front());
		void'(op_hist.pop_front());
		void'(a_hist.pop_front());
		void'(b_hist.pop_front());
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > TIMEOUT)
		begin
			$display("Run passed the limit of %0d cycles without finishing", TIMEOUT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// Outputs settle after the rising edge so they are read on the falling one
	always @(negedge clk)
	begin
		if (!rst_i)
		begin
			if (valid_o === 1'b1)
			begin
				if (expect_q.size() == 0)
				begin
					other_errors++;
					$display("valid_o went high at %0t with no operation outstanding", $time);
				end
				else
				begin
					checks++;
					if (cycle_count != due_q[0])
					begin
						timing_errors++;
						$display("[ERROR] %0t: %s result came in cycle %0d, due in cycle %0d",
							$time, op_hist[0].name(), cycle_count, due_q[0]);
					end
					if (result_o !== expect_q[0])
					begin
						value_errors++;
						$display("[ERROR] %0t: %s %h, %h gave %h, expected %h", $time,
							op_hist[0].name(), a_hist[0], b_hist[0], result_o, expect_q[0]);
					end
					drop_head();
				end
			end
			else if (valid_o !== 1'b0)
			begin
				other_errors++;
				$display("valid_o was unknown at %0t", $time);
			end
			else if (expect_q.size() != 0 && due_q[0] <= cycle_count)
			begin
				timing_errors++;
				$display("[ERROR] %0t: %s result due in cycle %0d did not appear",
					$time, op_hist[0].name(), due_q[0]);
				drop_head();
			end
		end
	end

	initial
	begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		alu_op_t op;
		int drain;
		seed = 27;
		rst_i = 1'b1;
		valid_i = 1'b0;
		op_i = OP_FADD;
		operand1_i = '0;
		operand2_i = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_i = 1'b0;
		@(negedge clk);
		if (valid_o !== 1'b0 || result_o !== '0)
		begin
			other_errors++;
			$display("Outputs were not cleared by reset at %0t", $time);
		end
		repeat (IDLE_CYCLES) idle_cycle();  // valid_o must stay low here

		issue_op(OP_FADD, 32'h3F80_0000, 32'h3F80_0000);
		issue_op(OP_FADD, 32'h3FC0_0000, 32'h4010_0000);
		issue_op(OP_FADD, 32'h3F80_0000, 32'h3080_0000);  // Gap of 30
		issue_op(OP_FADD, 32'h5380_0000, 32'hBF80_0000);  // Gap past the shifter
		issue_op(OP_FSUB, 32'h3FC0_0000, 32'h3FC0_0000);
		issue_op(OP_FADD, 32'h4049_0FDB, 32'hC049_0FDB);
		issue_op(OP_FADD, 32'h4040_0000, 32'hBF80_0000);
		issue_op(OP_FADD, 32'hBF80_0000, 32'h4040_0000);
		issue_op(OP_FSUB, 32'hC0A0_0000, 32'h4020_0000);
		issue_op(OP_FSUB, 32'h3F80_0000, 32'h3F80_0001);  // Long renormalize
		issue_op(OP_FADD, 32'h7F80_0000, 32'h3F80_0000);
		issue_op(OP_FSUB, 32'h7F80_0000, 32'h7F80_0000);
		issue_op(OP_FADD, 32'h7FC0_0000, 32'h3F80_0000);

		issue_op(OP_FMUL, 32'h4000_0000, 32'h4040_0000);
		issue_op(OP_FMUL, 32'h3FC0_0000, 32'hC020_0000);
		issue_op(OP_FMUL, 32'h3F8C_CCCD, 32'h4048_F5C3);
		issue_op(OP_FMUL, 32'h3FFF_FFFF, 32'h3FFF_FFFF);
		issue_op(OP_FMUL, 32'h7F7F_FFFF, 32'h3F80_0000);
		issue_op(OP_FMUL, 32'h7F00_0000, 32'h4000_0000);  // Overflow
		issue_op(OP_FMUL, 32'h7E80_0000, 32'h7E80_0000);
		issue_op(OP_FMUL, 32'h0080_0000, 32'h0080_0000);  // Underflow
		issue_op(OP_FMUL, 32'h0D80_0000, 32'h0D80_0000);
		issue_op(OP_FMUL, 32'h0000_0000, 32'h4049_0FDB);
		issue_op(OP_FMUL, 32'h8000_0000, 32'hC000_0000);
		issue_op(OP_FMUL, 32'h7FC0_0000, 32'h3F80_0000);
		issue_op(OP_FMUL, 32'h7F80_0000, 32'h0000_0000);  // inf * 0

		issue_op(OP_IMUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
		for (int i = 0; i < N_IMUL; i++)
		begin
			a = $random(seed);
			b = $random(seed);
			issue_op(OP_IMUL, a, b);
		end

		compare_all(32'h3F80_0000, 32'h3F80_0000);
		compare_all(32'h3F80_0000, 32'h4000_0000);
		compare_all(32'h4000_0000, 32'h3F80_0000);
		compare_all(32'hBF80_0000, 32'h3F80_0000);
		compare_all(32'hC000_0000, 32'hBF80_0000);
		compare_all(32'hBF80_0000, 32'hC000_0000);
		compare_all(32'h0000_0000, 32'h8000_0000);  // Zeros of both signs

		for (int i = 0; i < N_RANDOM; i++)
		begin
			r = $random(seed);
			if (r[1:0] == 2'b00)
				idle_cycle();
			op = alu_op_t'(r[4:2]);
			if (op == OP_IMUL)
			begin
				a = $random(seed);
				b = $random(seed);
			end
			else
			begin
				random_float(a);
				random_float(b);
			end
			issue_op(op, a, b);
		end
		idle_cycle();

		drain = 0;
		while (expect_q.size() != 0 && drain < `ALU_LATENCY + 8)
		begin
			@(negedge clk);
			drain++;
		end
		repeat (2) @(negedge clk);  // Catch a stray valid_o
		@(posedge clk);
		#1;
		if (expect_q.size() != 0)
		begin
			other_errors++;
			$display("%0d operations never produced a result", expect_q.size());
		end
		$display("Checked %0d results: %0d value errors, %0d timing errors, %0d other errors",
			checks, value_errors, timing_errors, other_errors);
		if (value_errors + timing_errors + other_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
fp_alu_pkg.sv
fp_adder_align.sv
fp_adder_sum.sv
integer_multiplier.sv
fp_normalize.sv
multi_cycle_scalar_alu.sv
tb_multi_cycle_scalar_alu.sv
